// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_slurm16_pipeline
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_MSG ?= Done: no errors

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only if the pass message shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/slurm16_alt_fifo.sv
`include "slurm16_defines.svh"

module slurm16_alt_fifo (
	input  logic CLK,
	input  logic RSTb,
	input  logic load_pc,
	input  logic alt_write,
	input  logic alt_read,
	input  logic memory_is_instruction,
	input  slurm16_pkg::instr_t memory_in,
	input  slurm16_pkg::addr_t memory_address,
	output slurm16_pkg::instr_t alt_instr,
	output slurm16_pkg::addr_t alt_pc
);

	localparam int PTR_W = $clog2(`SLURM16_FIFO_DEPTH);

	slurm16_pkg::instr_t instr_mem [`SLURM16_FIFO_DEPTH];
	slurm16_pkg::addr_t pc_mem [`SLURM16_FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;	// Wraps at depth
	logic [PTR_W-1:0] rd_ptr;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (load_pc) begin
			wr_ptr <= '0;	// New path, drop what was stored
			rd_ptr <= '0;
		end else begin
			if (alt_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (alt_read)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Data words on the bus become bubbles
	always_ff @(posedge CLK) begin
		if (alt_write) begin
			instr_mem[wr_ptr] <= memory_is_instruction ? memory_in : slurm16_pkg::NOP_INSTRUCTION;
			pc_mem[wr_ptr] <= memory_is_instruction ? memory_address : '0;
		end
	end

	assign alt_instr = instr_mem[rd_ptr];
	assign alt_pc = pc_mem[rd_ptr];

endmodule

// File: hdl/slurm16_cpu_pipeline.sv
`include "slurm16_defines.svh"

module slurm16_cpu_pipeline (
	input  logic CLK,
	input  logic RSTb,
	input  logic is_executing,
	input  logic stall,
	input  logic load_pc,
	input  logic hazard1,
	input  logic memory_is_instruction,
	input  logic fetch_open,
	input  logic replay,
	input  logic modifies_flags0,
	input  slurm16_pkg::instr_t memory_in,
	input  slurm16_pkg::instr_t alt_instr,
	input  slurm16_pkg::addr_t memory_address,
	input  slurm16_pkg::addr_t alt_pc,
	input  slurm16_pkg::reg_idx_t hazard_reg0,
	output logic alt_read,
	output slurm16_pkg::instr_t pipeline_stage0,
	output slurm16_pkg::instr_t pipeline_stage1,
	output slurm16_pkg::instr_t pipeline_stage2,
	output slurm16_pkg::instr_t pipeline_stage3,
	output slurm16_pkg::instr_t pipeline_stage4,
	output slurm16_pkg::addr_t pc_stage4,
	output slurm16_pkg::instr_t imm_reg,
	output slurm16_pkg::reg_idx_t hazard_reg1,
	output slurm16_pkg::reg_idx_t hazard_reg2,
	output slurm16_pkg::reg_idx_t hazard_reg3,
	output logic modifies_flags1,
	output logic modifies_flags2,
	output logic modifies_flags3
);

	localparam int RB = `SLURM16_REGISTER_BITS;
	localparam int HI_W = $bits(slurm16_pkg::imm_hi_t);

	slurm16_pkg::addr_t pc_stage0;
	slurm16_pkg::addr_t pc_stage1;
	slurm16_pkg::addr_t pc_stage2;
	slurm16_pkg::addr_t pc_stage3;

	slurm16_pkg::instr_t stage0_d, stage1_d, stage2_d, stage3_d, stage4_d;
	slurm16_pkg::addr_t pc0_d, pc1_d, pc2_d, pc3_d, pc4_d;
	slurm16_pkg::reg_idx_t haz1_d, haz2_d, haz3_d;
	logic flags1_d, flags2_d, flags3_d;

	slurm16_pkg::imm_hi_t imm_hi;	// Latched prefix bits
	slurm16_pkg::imm_hi_t imm_hi_d;
	logic [3:0] op1;
	logic stage1_moves;

	always_comb begin
		// Paused by default: front holds, stage 4 drains to a bubble
		stage0_d = pipeline_stage0;
		stage1_d = pipeline_stage1;
		stage2_d = pipeline_stage2;
		stage3_d = pipeline_stage3;
		stage4_d = slurm16_pkg::NOP_INSTRUCTION;
		pc0_d = pc_stage0;
		pc1_d = pc_stage1;
		pc2_d = pc_stage2;
		pc3_d = pc_stage3;
		pc4_d = pc_stage4;
		haz1_d = hazard_reg1;
		haz2_d = hazard_reg2;
		haz3_d = hazard_reg3;
		flags1_d = modifies_flags1;
		flags2_d = modifies_flags2;
		flags3_d = modifies_flags3;
		alt_read = 1'b0;

		if (is_executing) begin
			if (fetch_open && memory_is_instruction) begin
				stage0_d = memory_in;
				pc0_d = memory_address;
			end else if (replay) begin	// Words stored during the stall
				stage0_d = alt_instr;
				pc0_d = alt_pc;
				alt_read = 1'b1;
			end else begin
				stage0_d = slurm16_pkg::NOP_INSTRUCTION;	// Masked fetch
			end

			stage1_d = pipeline_stage0;
			stage2_d = pipeline_stage1;
			stage3_d = pipeline_stage2;
			stage4_d = pipeline_stage3;
			pc1_d = pc_stage0;
			pc2_d = pc_stage1;
			pc3_d = pc_stage2;
			pc4_d = pc_stage3;
			haz1_d = hazard_reg0;
			haz2_d = hazard_reg1;
			haz3_d = hazard_reg2;
			flags1_d = modifies_flags0;
			flags2_d = modifies_flags1;
			flags3_d = modifies_flags2;

			// Hold fetch and decode, bubble into execute, let the back drain
			if (stall) begin
				stage0_d = pipeline_stage0;
				pc0_d = pc_stage0;
				alt_read = 1'b0;
				stage1_d = pipeline_stage1;
				pc1_d = pc_stage1;
				haz1_d = hazard_reg1;
				flags1_d = modifies_flags1;
				stage2_d = slurm16_pkg::NOP_INSTRUCTION;
				haz2_d = slurm16_pkg::R0;
				flags2_d = 1'b0;

				// Hazard only with stage 1, so that word can move on
				if (hazard1) begin
					stage1_d = slurm16_pkg::NOP_INSTRUCTION;
					haz1_d = slurm16_pkg::R0;
					flags1_d = 1'b0;
					stage2_d = pipeline_stage1;
					pc2_d = pc_stage1;
					haz2_d = hazard_reg1;
					flags2_d = modifies_flags1;
				end
			end
		end

		// Branch taken, nothing up to execute may complete
		if (load_pc) begin
			stage0_d = slurm16_pkg::NOP_INSTRUCTION;
			stage1_d = slurm16_pkg::NOP_INSTRUCTION;
			stage2_d = slurm16_pkg::NOP_INSTRUCTION;
			haz1_d = slurm16_pkg::R0;
			haz2_d = slurm16_pkg::R0;
			flags1_d = 1'b0;
			flags2_d = 1'b0;
			alt_read = 1'b0;
		end
	end

	assign op1 = pipeline_stage1[`SLURM16_BITS-1 -: 4];
	assign stage1_moves = is_executing && (!stall || hazard1);

	// Prefix bits survive NOPs and are used up by the next real word
	always_comb begin
		imm_hi_d = imm_hi;
		if (load_pc) begin
			imm_hi_d = '0;
		end else if (stage1_moves) begin
			if (op1 == slurm16_pkg::OP_IMM)
				imm_hi_d = pipeline_stage1[HI_W-1:0];
			else if (pipeline_stage1 != slurm16_pkg::NOP_INSTRUCTION)
				imm_hi_d = '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pipeline_stage0 <= slurm16_pkg::NOP_INSTRUCTION;
			pipeline_stage1 <= slurm16_pkg::NOP_INSTRUCTION;
			pipeline_stage2 <= slurm16_pkg::NOP_INSTRUCTION;
			pipeline_stage3 <= slurm16_pkg::NOP_INSTRUCTION;
			pipeline_stage4 <= slurm16_pkg::NOP_INSTRUCTION;
			pc_stage0 <= '0;
			pc_stage1 <= '0;
			pc_stage2 <= '0;
			pc_stage3 <= '0;
			pc_stage4 <= '0;
			hazard_reg1 <= slurm16_pkg::R0;
			hazard_reg2 <= slurm16_pkg::R0;
			hazard_reg3 <= slurm16_pkg::R0;
			modifies_flags1 <= 1'b0;
			modifies_flags2 <= 1'b0;
			modifies_flags3 <= 1'b0;
			imm_hi <= '0;
			imm_reg <= '0;
		end else begin
			pipeline_stage0 <= stage0_d;
			pipeline_stage1 <= stage1_d;
			pipeline_stage2 <= stage2_d;
			pipeline_stage3 <= stage3_d;
			pipeline_stage4 <= stage4_d;
			pc_stage0 <= pc0_d;
			pc_stage1 <= pc1_d;
			pc_stage2 <= pc2_d;
			pc_stage3 <= pc3_d;
			pc_stage4 <= pc4_d;
			hazard_reg1 <= haz1_d;
			hazard_reg2 <= haz2_d;
			hazard_reg3 <= haz3_d;
			modifies_flags1 <= flags1_d;
			modifies_flags2 <= flags2_d;
			modifies_flags3 <= flags3_d;
			imm_hi <= imm_hi_d;
			if (is_executing)
				imm_reg <= {imm_hi, pipeline_stage1[RB-1:0]};	// Lines up with stage 2
		end
	end

endmodule

// File: hdl/slurm16_hazard_unit.sv
`include "slurm16_defines.svh"

module slurm16_hazard_unit (
	input  slurm16_pkg::instr_t pipeline_stage0,
	input  slurm16_pkg::reg_idx_t hazard_reg1,
	input  slurm16_pkg::reg_idx_t hazard_reg2,
	input  slurm16_pkg::reg_idx_t hazard_reg3,
	output slurm16_pkg::reg_idx_t hazard_reg0,
	output logic modifies_flags0,
	output logic hazard_stall,
	output logic hazard1
);

	localparam int RB = `SLURM16_REGISTER_BITS;

	logic [3:0] opcode;
	slurm16_pkg::reg_idx_t dest;
	slurm16_pkg::reg_idx_t src_a;
	slurm16_pkg::reg_idx_t src_b;
	logic is_alu;
	logic a_live;
	logic b_live;
	logic match1;
	logic match23;

	// Field split of the stage 0 word
	assign opcode = pipeline_stage0[`SLURM16_BITS-1 -: 4];
	assign dest = pipeline_stage0[3*RB-1 -: RB];
	assign src_a = pipeline_stage0[2*RB-1 -: RB];
	assign src_b = pipeline_stage0[RB-1:0];
	assign is_alu = (opcode == slurm16_pkg::OP_ALU);

	always_comb begin
		case (opcode)
			slurm16_pkg::OP_ALU, slurm16_pkg::OP_LDI: hazard_reg0 = dest;
			default: hazard_reg0 = slurm16_pkg::R0;	// NOP and prefix write nothing
		endcase
	end

	assign modifies_flags0 = is_alu;

	// Only ALU words read registers
	assign a_live = is_alu && (src_a != slurm16_pkg::R0);
	assign b_live = is_alu && (src_b != slurm16_pkg::R0);

	assign match1 = (a_live && src_a == hazard_reg1) || (b_live && src_b == hazard_reg1);
	assign match23 = (a_live && (src_a == hazard_reg2 || src_a == hazard_reg3)) ||
		(b_live && (src_b == hazard_reg2 || src_b == hazard_reg3));

	assign hazard_stall = match1 || match23;
	assign hazard1 = match1 && !match23;	// Stage 1 may be let through

endmodule

// File: hdl/slurm16_mask_timer.sv
`include "slurm16_defines.svh"

module slurm16_mask_timer (
	input  logic CLK,
	input  logic RSTb,
	input  logic is_executing,
	input  logic load_pc,
	input  logic stall_start,
	input  logic stall_end,
	output logic fetch_open,
	output logic replay,
	output logic alt_write
);

	localparam int MASK_W = $clog2(`SLURM16_MASK_RELOAD + 1);
	localparam int REPLAY_W = $clog2(`SLURM16_STALL_MASK_RELOAD + 1);

	logic [MASK_W-1:0] mask_count;		// Fetch blanked while nonzero
	logic [REPLAY_W-1:0] replay_count;	// FIFO feeds stage 0 while nonzero
	logic alt_ld_count;			// Second in-flight word still to store

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			mask_count <= MASK_W'(`SLURM16_MASK_RELOAD);	// Blank fetch out of reset
			replay_count <= '0;
			alt_ld_count <= 1'b0;
		end else begin
			// Memory output is stale after a PC load
			if (load_pc)
				mask_count <= MASK_W'(`SLURM16_MASK_RELOAD);
			else if (is_executing && mask_count != '0)
				mask_count <= mask_count - 1'b1;

			if (load_pc)
				replay_count <= '0;	// Stored words belong to the old path
			else if (stall_end)
				replay_count <= REPLAY_W'(`SLURM16_STALL_MASK_RELOAD);
			else if (is_executing && replay_count != '0)
				replay_count <= replay_count - 1'b1;

			if (load_pc)
				alt_ld_count <= 1'b0;
			else
				alt_ld_count <= stall_start;
		end
	end

	assign replay = (replay_count != '0);
	assign fetch_open = (mask_count == '0) && (replay_count == '0);

	// Capture the words that were already on their way from memory
	assign alt_write = (stall_start || alt_ld_count) && !load_pc && !replay;

endmodule

// File: hdl/slurm16_pipeline_top.sv
module slurm16_pipeline_top (
	input  logic CLK,
	input  logic RSTb,
	input  slurm16_pkg::instr_t memory_in,
	input  slurm16_pkg::addr_t memory_address,
	input  logic memory_is_instruction,
	input  logic is_executing,
	input  logic load_pc,
	output slurm16_pkg::instr_t pipeline_stage0,
	output slurm16_pkg::instr_t pipeline_stage1,
	output slurm16_pkg::instr_t pipeline_stage2,
	output slurm16_pkg::instr_t pipeline_stage3,
	output slurm16_pkg::instr_t pipeline_stage4,
	output slurm16_pkg::addr_t pc_stage4,
	output slurm16_pkg::instr_t imm_reg,
	output slurm16_pkg::reg_idx_t hazard_reg1,
	output slurm16_pkg::reg_idx_t hazard_reg2,
	output slurm16_pkg::reg_idx_t hazard_reg3,
	output logic modifies_flags1,
	output logic modifies_flags2,
	output logic modifies_flags3,
	output logic stall
);

	slurm16_pkg::reg_idx_t hazard_reg0;
	logic modifies_flags0;
	logic hazard_stall;
	logic hazard1;
	logic stall_start;
	logic stall_end;
	logic fetch_open;
	logic replay;
	logic alt_write;
	logic alt_read;
	slurm16_pkg::instr_t alt_instr;
	slurm16_pkg::addr_t alt_pc;

	slurm16_hazard_unit u_hazard (
		.pipeline_stage0(pipeline_stage0),
		.hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2),
		.hazard_reg3(hazard_reg3),
		.hazard_reg0(hazard_reg0),
		.modifies_flags0(modifies_flags0),
		.hazard_stall(hazard_stall),
		.hazard1(hazard1)
	);

	slurm16_stall_fsm u_stall_fsm (
		.CLK(CLK),
		.RSTb(RSTb),
		.is_executing(is_executing),
		.load_pc(load_pc),
		.hazard_stall(hazard_stall),
		.stall(stall),
		.stall_start(stall_start),
		.stall_end(stall_end)
	);

	slurm16_mask_timer u_mask_timer (
		.CLK(CLK),
		.RSTb(RSTb),
		.is_executing(is_executing),
		.load_pc(load_pc),
		.stall_start(stall_start),
		.stall_end(stall_end),
		.fetch_open(fetch_open),
		.replay(replay),
		.alt_write(alt_write)
	);

	slurm16_alt_fifo u_alt_fifo (
		.CLK(CLK),
		.RSTb(RSTb),
		.load_pc(load_pc),
		.alt_write(alt_write),
		.alt_read(alt_read),
		.memory_is_instruction(memory_is_instruction),
		.memory_in(memory_in),
		.memory_address(memory_address),
		.alt_instr(alt_instr),
		.alt_pc(alt_pc)
	);

	slurm16_cpu_pipeline u_pipeline (
		.CLK(CLK),
		.RSTb(RSTb),
		.is_executing(is_executing),
		.stall(stall),
		.load_pc(load_pc),
		.hazard1(hazard1),
		.memory_is_instruction(memory_is_instruction),
		.fetch_open(fetch_open),
		.replay(replay),
		.modifies_flags0(modifies_flags0),
		.memory_in(memory_in),
		.alt_instr(alt_instr),
		.memory_address(memory_address),
		.alt_pc(alt_pc),
		.hazard_reg0(hazard_reg0),
		.alt_read(alt_read),
		.pipeline_stage0(pipeline_stage0),
		.pipeline_stage1(pipeline_stage1),
		.pipeline_stage2(pipeline_stage2),
		.pipeline_stage3(pipeline_stage3),
		.pipeline_stage4(pipeline_stage4),
		.pc_stage4(pc_stage4),
		.imm_reg(imm_reg),
		.hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2),
		.hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1),
		.modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3)
	);

endmodule

// File: hdl/slurm16_pkg.sv
`include "slurm16_defines.svh"

package slurm16_pkg;

	// Instruction word, 4-bit opcode on top
	typedef logic [`SLURM16_BITS-1:0] instr_t;

	typedef logic [`SLURM16_ADDRESS_BITS-1:0] addr_t;

	typedef logic [`SLURM16_REGISTER_BITS-1:0] reg_idx_t;

	// Upper immediate bits carried by a prefix word
	typedef logic [`SLURM16_BITS-`SLURM16_REGISTER_BITS-1:0] imm_hi_t;

	typedef enum logic {
		ST_RUN,
		ST_STALL
	} stall_state_t;

	localparam instr_t NOP_INSTRUCTION = '0;

	localparam reg_idx_t R0 = '0;	// Never a hazard

	// Opcodes in bits 15:12
	localparam logic [3:0] OP_IMM = 4'h1;	// Immediate prefix
	localparam logic [3:0] OP_ALU = 4'h2;	// Reg-reg, sets flags
	localparam logic [3:0] OP_LDI = 4'h3;	// Load immediate, flags untouched

endpackage

// File: hdl/slurm16_stall_fsm.sv
module slurm16_stall_fsm (
	input  logic CLK,
	input  logic RSTb,
	input  logic is_executing,
	input  logic load_pc,
	input  logic hazard_stall,
	output logic stall,
	output logic stall_start,
	output logic stall_end
);

	slurm16_pkg::stall_state_t state;
	slurm16_pkg::stall_state_t state_next;

	// First cycle of a hazard while running
	assign stall_start = (state == slurm16_pkg::ST_RUN) && hazard_stall &&
		is_executing && !load_pc;

	// Hazard gone, stall held one more cycle so the FIFO replay lines up
	assign stall_end = (state == slurm16_pkg::ST_STALL) && !hazard_stall &&
		is_executing && !load_pc;

	assign stall = stall_start || ((state == slurm16_pkg::ST_STALL) && !load_pc);

	always_comb begin
		state_next = state;
		case (state)
			slurm16_pkg::ST_RUN: begin
				if (stall_start)
					state_next = slurm16_pkg::ST_STALL;
			end
			slurm16_pkg::ST_STALL: begin
				if (load_pc || stall_end)	// Branch cancels the stall silently
					state_next = slurm16_pkg::ST_RUN;
			end
			default: state_next = slurm16_pkg::ST_RUN;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state <= slurm16_pkg::ST_RUN;
		else
			state <= state_next;
	end

endmodule

// File: include/slurm16_defines.svh
`ifndef SLURM16_DEFINES_SVH
`define SLURM16_DEFINES_SVH

// Word and bus widths
`define SLURM16_BITS 16
`define SLURM16_ADDRESS_BITS 16
`define SLURM16_REGISTER_BITS 4

// Alternate FIFO, pointer width follows from the depth
`define SLURM16_FIFO_DEPTH 8

// Fetches blanked after reset or a PC load
`define SLURM16_MASK_RELOAD 2

// Cycles that stage 0 is fed from the FIFO once a stall ends
`define SLURM16_STALL_MASK_RELOAD 2

`endif

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;	// 4 ns period
	end

	// Reset held low for five rising edges
	initial begin
		RSTb = 1'b0;
		repeat (5) @(posedge CLK);
		#1 RSTb = 1'b1;
	end

endmodule

// File: testbench/tb_slurm16_pipeline.sv
module tb_slurm16_pipeline;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MASK_CYCLES = 2;
	localparam int REPLAY_CYCLES = 2;
	localparam int WAIT_LIMIT = 20;

	logic CLK;
	logic RSTb;
	slurm16_pkg::instr_t memory_in;
	slurm16_pkg::addr_t memory_address;
	logic memory_is_instruction;
	logic is_executing;
	logic load_pc;
	slurm16_pkg::instr_t pipeline_stage0;
	slurm16_pkg::instr_t pipeline_stage1;
	slurm16_pkg::instr_t pipeline_stage2;
	slurm16_pkg::instr_t pipeline_stage3;
	slurm16_pkg::instr_t pipeline_stage4;
	slurm16_pkg::addr_t pc_stage4;
	slurm16_pkg::instr_t imm_reg;
	slurm16_pkg::reg_idx_t hazard_reg1;
	slurm16_pkg::reg_idx_t hazard_reg2;
	slurm16_pkg::reg_idx_t hazard_reg3;
	logic modifies_flags1;
	logic modifies_flags2;
	logic modifies_flags3;
	logic stall;

	slurm16_pkg::instr_t prog [256];	// Program memory indexed by address
	int mismatch_count;
	int timeout_count;
	logic [31:0] lfsr_state;
	slurm16_pkg::addr_t fetch_addr;	// Fetch side PC
	int mask_left;
	int stall_run;
	int replay_left;
	logic stall_seen;

	tb_clock_gen clock_gen (
		.CLK(CLK),
		.RSTb(RSTb)
	);

	slurm16_pipeline_top UUT (
		.CLK(CLK),
		.RSTb(RSTb),
		.memory_in(memory_in),
		.memory_address(memory_address),
		.memory_is_instruction(memory_is_instruction),
		.is_executing(is_executing),
		.load_pc(load_pc),
		.pipeline_stage0(pipeline_stage0),
		.pipeline_stage1(pipeline_stage1),
		.pipeline_stage2(pipeline_stage2),
		.pipeline_stage3(pipeline_stage3),
		.pipeline_stage4(pipeline_stage4),
		.pc_stage4(pc_stage4),
		.imm_reg(imm_reg),
		.hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2),
		.hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1),
		.modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3),
		.stall(stall)
	);

	assign memory_in = prog[memory_address[7:0]];	// Zero-latency memory

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic slurm16_pkg::reg_idx_t random_reg();
		slurm16_pkg::reg_idx_t r;
		for (int i = 0; i < 4; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r[i] = lfsr_state[0];
		end
		if (r == slurm16_pkg::R0)
			r = 4'd1;	// Keep it a real register
		return r;
	endfunction

	function automatic slurm16_pkg::instr_t stage_of(input int idx);
		case (idx)
			0: return pipeline_stage0;
			1: return pipeline_stage1;
			2: return pipeline_stage2;
			3: return pipeline_stage3;
			default: return pipeline_stage4;
		endcase
	endfunction

	// One clock. Mid-cycle the fetch side decides whether its word was consumed
	task automatic tick();
		logic advance;
		@(negedge CLK);
		advance = 1'b0;
		if (stall)
			stall_seen = 1'b1;
		if (load_pc) begin
			mask_left = MASK_CYCLES;
			stall_run = 0;
			replay_left = 0;
		end else if (is_executing) begin
			if (mask_left > 0) begin
				mask_left--;
			end else if (stall) begin
				advance = (stall_run < 2);	// Two words in flight get stored
				stall_run++;
			end else if (stall_run > 0) begin
				stall_run = 0;
				replay_left = REPLAY_CYCLES - 1;	// First replay cycle is this one
			end else if (replay_left > 0) begin
				replay_left--;
			end else begin
				advance = 1'b1;
			end
		end
		@(posedge CLK);
		#1;
		if (advance)
			fetch_addr = fetch_addr + 16'd1;
		memory_address = fetch_addr;
	endtask

	task automatic jump(input slurm16_pkg::addr_t target);
		load_pc = 1'b1;
		fetch_addr = target;
		memory_address = target;
		tick();
		load_pc = 1'b0;
	endtask

	task automatic wait_stage(input int idx, input slurm16_pkg::instr_t word, input string what);
		int n;
		n = 0;
		while (stage_of(idx) !== word && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (stage_of(idx) !== word) begin
			timeout_count++;
			$display("Timeout waiting for %s in stage %0d", what, idx);
		end
	endtask

	task automatic reset_and_mask();
		check("pipeline_stage0", pipeline_stage0, 16'h0000);
		check("pipeline_stage1", pipeline_stage1, 16'h0000);
		check("pipeline_stage2", pipeline_stage2, 16'h0000);
		check("pipeline_stage3", pipeline_stage3, 16'h0000);
		check("pipeline_stage4", pipeline_stage4, 16'h0000);
		check("hazard_reg1", 16'(hazard_reg1), 16'h0000);
		check("hazard_reg2", 16'(hazard_reg2), 16'h0000);
		check("hazard_reg3", 16'(hazard_reg3), 16'h0000);
		prog[0] = {4'h3, random_reg(), 8'h07};
		is_executing = 1'b1;
		tick();
		check("pipeline_stage0", pipeline_stage0, 16'h0000);	// Masked
		tick();
		check("pipeline_stage0", pipeline_stage0, 16'h0000);
		tick();
		check("pipeline_stage0", pipeline_stage0, prog[0]);
	endtask

	task automatic straight_flow();
		slurm16_pkg::reg_idx_t dest;
		for (int i = 0; i < 4; i++)
			prog[8'(32 + i)] = {4'h3, random_reg(), 4'h0, 4'(i)};
		jump(16'h0020);
		wait_stage(0, prog[8'h20], "first LDI");
		dest = prog[8'h20][11:8];
		tick();
		check("pipeline_stage1", pipeline_stage1, prog[8'h20]);
		check("hazard_reg1", 16'(hazard_reg1), 16'(dest));
		check("modifies_flags1", 16'(modifies_flags1), 16'h0000);	// LDI keeps flags
		tick();
		tick();
		tick();
		for (int i = 0; i < 4; i++) begin
			check("pipeline_stage4", pipeline_stage4, prog[8'(32 + i)]);
			check("pc_stage4", pc_stage4, 16'(32 + i));
			tick();
		end
	endtask

	task automatic immediate_prefix();
		slurm16_pkg::reg_idx_t ry;
		ry = random_reg();
		prog[8'h30] = 16'h1abc;	// Prefix
		prog[8'h31] = {4'h3, random_reg(), 4'h0, 4'hd};
		prog[8'h32] = {4'h2, ry, 8'h00};	// ALU without prefix and with R0 sources
		jump(16'h0030);
		wait_stage(2, prog[8'h31], "LDI after prefix");
		check("imm_reg", imm_reg, 16'habcd);
		tick();
		check("pipeline_stage2", pipeline_stage2, prog[8'h32]);
		check("imm_reg", imm_reg, 16'h0000);
		check("modifies_flags2", 16'(modifies_flags2), 16'h0001);
		tick();
		check("modifies_flags3", 16'(modifies_flags3), 16'h0001);
		check("hazard_reg3", 16'(hazard_reg3), 16'(ry));
	endtask

	task automatic flush_on_load();
		prog[8'h70] = {4'h3, random_reg(), 8'h0e};
		jump(16'h0070);
		check("pipeline_stage0", pipeline_stage0, 16'h0000);
		check("pipeline_stage1", pipeline_stage1, 16'h0000);
		check("pipeline_stage2", pipeline_stage2, 16'h0000);
		tick();
		check("pipeline_stage0", pipeline_stage0, 16'h0000);
		tick();
		check("pipeline_stage0", pipeline_stage0, 16'h0000);
		tick();
		check("pipeline_stage0", pipeline_stage0, prog[8'h70]);
	endtask

	task automatic hazard_replay();
		slurm16_pkg::instr_t exp_word[$];
		slurm16_pkg::addr_t exp_pc[$];
		slurm16_pkg::reg_idx_t ra;
		int cycles;
		ra = random_reg();
		prog[8'h40] = {4'h3, ra, 8'h05};
		prog[8'h41] = {4'h2, random_reg(), ra, 4'h0};	// Reads the LDI result
		for (int i = 2; i < 6; i++)
			prog[8'(64 + i)] = {4'h3, random_reg(), 4'h0, 4'(i)};
		for (int i = 0; i < 6; i++) begin
			exp_word.push_back(prog[8'(64 + i)]);
			exp_pc.push_back(16'(64 + i));
		end
		jump(16'h0040);
		tick();	// Older words drain out of stage 4
		tick();
		stall_seen = 1'b0;
		cycles = 0;
		while (exp_word.size() > 0 && cycles < 60) begin
			tick();
			cycles++;
			if (pipeline_stage4 != slurm16_pkg::NOP_INSTRUCTION) begin
				check("pipeline_stage4", pipeline_stage4, exp_word.pop_front());
				check("pc_stage4", pc_stage4, exp_pc.pop_front());
			end
		end
		if (exp_word.size() > 0) begin
			timeout_count++;
			$display("Timeout: %0d program words never reached stage 4", exp_word.size());
		end
		check("stall", 16'(stall_seen), 16'h0001);
	endtask

	task automatic execution_pause();
		slurm16_pkg::instr_t saved [4];
		jump(16'h0060);
		wait_stage(0, prog[8'h60], "word at 0x60");
		tick();
		tick();
		tick();
		// Words 0x63 down to 0x60 now sit in stages 0 to 3
		for (int i = 0; i < 4; i++)
			saved[i] = prog[8'(8'h63 - i)];
		is_executing = 1'b0;
		repeat (3) begin
			tick();
			check("pipeline_stage0", pipeline_stage0, saved[0]);
			check("pipeline_stage1", pipeline_stage1, saved[1]);
			check("pipeline_stage2", pipeline_stage2, saved[2]);
			check("pipeline_stage3", pipeline_stage3, saved[3]);
			check("pipeline_stage4", pipeline_stage4, 16'h0000);
		end
		is_executing = 1'b1;
		tick();
		check("pipeline_stage1", pipeline_stage1, saved[0]);
		check("pipeline_stage4", pipeline_stage4, saved[3]);
	endtask

	initial begin
		int n;
		memory_address = '0;
		memory_is_instruction = 1'b1;
		is_executing = 1'b0;
		load_pc = 1'b0;
		mismatch_count = 0;
		timeout_count = 0;
		lfsr_state = 32'h4a2ce084;
		fetch_addr = '0;
		mask_left = MASK_CYCLES;
		stall_run = 0;
		replay_left = 0;
		stall_seen = 1'b0;
		// LDI to R0 with the address in the low byte
		for (int a = 0; a < 256; a++)
			prog[a] = {4'h3, 4'h0, 8'(a)};

		n = 0;
		while (RSTb !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge CLK);
			n++;
		end
		if (RSTb !== 1'b1) begin
			timeout_count++;
			$display("Timeout: reset was never released");
		end
		@(posedge CLK);
		#1;

		reset_and_mask();
		straight_flow();
		immediate_prefix();
		flush_on_load();
		hazard_replay();
		execution_pause();

		$display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
hdl/slurm16_pkg.sv
hdl/slurm16_hazard_unit.sv
hdl/slurm16_stall_fsm.sv
hdl/slurm16_mask_timer.sv
hdl/slurm16_alt_fifo.sv
hdl/slurm16_cpu_pipeline.sv
hdl/slurm16_pipeline_top.sv
testbench/tb_clock_gen.sv
testbench/tb_slurm16_pipeline.sv
